// File: efpga_test_top.f
+incdir+dv
common/efpga_bus_pkg.sv
common/efpga_map_pkg.sv
verilog/read_delay_timer.sv
verilog/host_bus_fsm.sv
verilog/ctrl_regs.sv
dma/oper_ram.sv
dma/dma_channel.sv
verilog/efpga_test_top.sv
dv/tb_clock.sv
dv/efpga_test_tb.sv

// File: Bender.yml
package:
  name: efpga_test_fabric

sources:
  - files:
      - common/efpga_bus_pkg.sv
      - common/efpga_map_pkg.sv
      - verilog/read_delay_timer.sv
      - verilog/host_bus_fsm.sv
      - verilog/ctrl_regs.sv
      - dma/oper_ram.sv
      - dma/dma_channel.sv
      - verilog/efpga_test_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_clock.sv
      - dv/efpga_test_tb.sv

// File: dv/efpga_test_model.svh
// Reference model for the fabric testbench: random number source, mirror of
// the operand RAM and registers, and the TCDM memory behind the responder.
// Included inside the testbench module after the package imports.
`ifndef EFPGA_TEST_MODEL_SVH
`define EFPGA_TEST_MODEL_SVH

localparam logic [31:0] LCG_SEED = 32'd70;

logic [31:0]       rng_state;
logic [DATA_W-1:0] model_ram [RAM_WORDS];
logic [DATA_W-1:0] tcdm_mem [1024];  // responder storage
logic [DATA_W-1:0] model_gpio_out;
logic [DATA_W-1:0] model_gpio_oe;
dma_cfg_t          model_cfg;
int                tcdm_writes;  // write grants in the current burst

// numerical recipes constants
function automatic logic [31:0] lcg_step(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// upper halves of two steps, low bits cycle too fast
function automatic logic [31:0] rand_word();
  logic [31:0] hi;
  rng_state = lcg_step(rng_state);
  hi = rng_state;
  rng_state = lcg_step(rng_state);
  return {hi[31:16], rng_state[31:16]};
endfunction

function automatic int rand_below(input int n);
  return int'(rand_word() % n);
endfunction

// enabled bytes take the new value, the rest keep the old one
function automatic logic [DATA_W-1:0] apply_be(
  input logic [DATA_W-1:0] old_val,
  input logic [DATA_W-1:0] new_val,
  input logic [3:0]        be
);
  logic [DATA_W-1:0] mask;
  mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  return (old_val & ~mask) | (new_val & mask);
endfunction

`endif

// File: dv/efpga_test_tb.sv
// Testbench for the eFPGA test fabric. Drives the host bus on the falling
// edge, answers the TCDM port with a behavioral memory and checks registers,
// GPIO, the RAM window, both DMA directions and the delayed read.
`timescale 1ns/100ps

module efpga_test_tb
  import efpga_bus_pkg::*;
  import efpga_map_pkg::*;
();

  localparam int TIMEOUT   = 1000;  // cycles per wait
  localparam int RAM_WORDS = 256;

  logic              CLK;
  logic              reset;
  host_req_t         host_req;
  host_rsp_t         host_rsp;
  tcdm_req_t         tcdm_req;
  tcdm_rsp_t         tcdm_rsp;
  logic [DATA_W-1:0] gpio_in;
  logic [DATA_W-1:0] gpio_out;
  logic [DATA_W-1:0] gpio_oe;
  int                read_cycles;  // sampled edge to valid, last read

  `include "efpga_test_model.svh"

  tb_clock u_clock (.CLK(CLK), .reset(reset));

  efpga_test_top #(.RAM_DEPTH(RAM_WORDS)) uut (
    .CLK(CLK), .reset(reset), .host_req(host_req), .host_rsp(host_rsp),
    .tcdm_req(tcdm_req), .tcdm_rsp(tcdm_rsp), .gpio_in(gpio_in),
    .gpio_out(gpio_out), .gpio_oe(gpio_oe)
  );

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_cfg(input string name, input dma_cfg_t exp, input dma_cfg_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_rsp_flags(input string name, input host_rsp_t act,
                                 input logic exp_gnt, input logic exp_valid);
    if ({act.gnt, act.valid} !== {exp_gnt, exp_valid}) begin
      $display("FAILED %s expected gnt/valid %b%b actual %b%b", name,
               exp_gnt, exp_valid, act.gnt, act.valid);
      stop_run();
    end
  endtask

  function automatic logic [ADDR_W-1:0] ram_addr(input int idx);
    return {REGION_RAM, 10'(idx), 2'b00};
  endfunction

  // gnt one cycle and valid two cycles after the sampled req
  task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [3:0] be);
    host_req.req   = 1'b1;
    host_req.wen   = 1'b0;
    host_req.addr  = addr;
    host_req.wdata = data;
    host_req.be    = be;
    @(negedge CLK);
    check_rsp_flags("write grant", host_rsp, 1'b1, 1'b0);
    @(negedge CLK);
    check_rsp_flags("write valid", host_rsp, 1'b0, 1'b1);
    host_req.req = 1'b0;
    @(negedge CLK);  // req seen low before the next rise
  endtask

  task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    int   cycles;
    logic gnt_seen;
    cycles   = 0;
    gnt_seen = 1'b0;
    host_req.req   = 1'b1;
    host_req.wen   = 1'b1;
    host_req.addr  = addr;
    host_req.wdata = '0;
    host_req.be    = '1;
    @(negedge CLK);
    while (!host_rsp.valid && cycles < TIMEOUT) begin
      gnt_seen = gnt_seen | host_rsp.gnt;
      @(negedge CLK);
      cycles++;
    end
    if (!host_rsp.valid) begin
      $display("read at %h got no valid within %0d cycles", addr, cycles);
      stop_run();
    end
    if (!gnt_seen) begin
      $display("read at %h completed without a grant", addr);
      stop_run();
    end
    read_cycles  = cycles;
    data         = host_rsp.rdata;
    host_req.req = 1'b0;
    @(negedge CLK);
  endtask

  task automatic wait_dma_done();
    logic [DATA_W-1:0] status;
    int                polls;
    polls = 0;
    host_read({8'h00, OFS_DMA_STATUS}, status);
    check_word("dma busy after launch", 32'd1, status);
    while (status[0] && polls < TIMEOUT) begin
      host_read({8'h00, OFS_DMA_STATUS}, status);
      polls++;
    end
    if (status[0]) begin
      $display("DMA still busy after %0d status reads", polls);
      stop_run();
    end
    check_word("tcdm req after burst", 32'd0, 32'(tcdm_req.req));
  endtask

  task automatic run_dma(input logic to_ram);
    dma_cfg_t          cfg;
    logic [DATA_W-1:0] rd;
    int                count;
    int                base;
    count         = 1 + rand_below(16);
    base          = rand_below(1024 - count);
    cfg           = '0;
    cfg.to_ram    = to_ram;
    cfg.count     = 8'(count);
    cfg.tcdm_addr = TCDM_ADDR_W'(base * 4);
    tcdm_writes   = 0;
    host_write({8'h00, OFS_DMA_CFG}, cfg, 4'hf);
    model_cfg = cfg;
    host_write({8'h00, OFS_DMA_LAUNCH}, '0, 4'hf);
    wait_dma_done();
    for (int i = 0; i < count; i++) begin
      if (to_ram) begin
        model_ram[i] = tcdm_mem[base + i];
        host_read(ram_addr(i), rd);
        check_word("dma into ram", model_ram[i], rd);
      end else begin
        check_word("dma out of ram", model_ram[i], tcdm_mem[base + i]);
      end
    end
    check_word("tcdm write count", to_ram ? 32'd0 : 32'(count), 32'(tcdm_writes));
  endtask

  // TCDM memory that grants after 0..3 cycles and answers 1..3 cycles later
  initial begin
    logic [31:0] resp_rng;
    int          phase;  // 0 idle, 1 grant pending, 2 valid pending
    int          gnt_wait;
    int          val_wait;
    logic        is_read;
    logic [9:0]  word;
    tcdm_rsp = '0;
    resp_rng = ~LCG_SEED;
    phase    = 0;
    for (int i = 0; i < 1024; i++) begin
      resp_rng    = lcg_step(resp_rng);
      tcdm_mem[i] = resp_rng ^ 32'(i);
    end
    forever begin
      @(negedge CLK);
      tcdm_rsp.gnt   = 1'b0;
      tcdm_rsp.valid = 1'b0;
      if (phase == 0 && tcdm_req.req) begin
        resp_rng = lcg_step(resp_rng);
        gnt_wait = resp_rng[31:30];
        phase    = 1;
      end
      if (phase == 1) begin
        if (gnt_wait == 0) begin
          tcdm_rsp.gnt = 1'b1;
          is_read      = tcdm_req.wen;
          word         = tcdm_req.addr[11:2];
          // bursts stay word aligned inside the 4 KB memory
          check_word("tcdm addr outside memory", 32'd0,
                     32'({tcdm_req.addr[TCDM_ADDR_W-1:12], tcdm_req.addr[1:0]}));
          if (!is_read) begin
            check_word("tcdm write be", 32'hf, 32'(tcdm_req.be));
            tcdm_mem[word] = tcdm_req.wdata;
            tcdm_writes++;
          end
          resp_rng = lcg_step(resp_rng);
          val_wait = 1 + resp_rng[31:16] % 3;
          phase    = 2;
        end else begin
          gnt_wait--;
        end
      end else if (phase == 2) begin
        val_wait--;
        if (val_wait == 0) begin
          tcdm_rsp.valid = 1'b1;
          tcdm_rsp.rdata = is_read ? tcdm_mem[word] : '0;
          phase          = 0;
        end
      end
    end
  end

  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] data;
    logic [3:0]        be;
    logic [ADDR_W-1:0] addr;
    int                sel;
    int                idx;
    int                delay;
    int                cycles;
    host_req       = '0;
    gpio_in        = '0;
    rng_state      = LCG_SEED;
    model_gpio_out = '0;
    model_gpio_oe  = '0;
    model_cfg      = '0;
    read_cycles    = 0;
    cycles         = 0;
    @(posedge CLK);
    while (reset && cycles < 20) begin
      @(posedge CLK);
      cycles++;
    end
    if (reset) begin
      $display("reset never released");
      stop_run();
    end
    @(negedge CLK);

    check_rsp_flags("reset flags", host_rsp, 1'b0, 1'b0);
    check_word("reset rdata", '1, host_rsp.rdata);
    check_word("reset tcdm req", 32'd0, 32'(tcdm_req.req));
    check_word("reset gpio_oe", 32'd0, gpio_oe);
    host_read({8'h00, OFS_ID}, rd);
    check_word("id read", ID_VALUE, rd);

    for (int n = 0; n < 24; n++) begin
      sel  = rand_below(3);
      data = rand_word();
      be   = 4'(rand_below(16));
      case (sel)
        0: begin
          host_write({8'h00, OFS_GPIO_OUT}, data, be);
          model_gpio_out = apply_be(model_gpio_out, data, be);
          host_read({8'h00, OFS_GPIO_OUT}, rd);
          check_word("gpio_out readback", model_gpio_out, rd);
        end
        1: begin
          host_write({8'h00, OFS_GPIO_OE}, data, be);
          model_gpio_oe = apply_be(model_gpio_oe, data, be);
          host_read({8'h00, OFS_GPIO_OE}, rd);
          check_word("gpio_oe readback", model_gpio_oe, rd);
        end
        default: begin
          host_write({8'h00, OFS_DMA_CFG}, data, be);
          model_cfg = dma_cfg_t'(apply_be(model_cfg, data, be));
          host_read({8'h00, OFS_DMA_CFG}, rd);
          check_cfg("dma cfg readback", model_cfg, dma_cfg_t'(rd));
        end
      endcase
      check_word("gpio_out pins", model_gpio_out, gpio_out);
      check_word("gpio_oe pins", model_gpio_oe, gpio_oe);
    end
    gpio_in = rand_word();
    host_read({8'h00, OFS_GPIO_IN}, rd);
    check_word("gpio_in read", gpio_in, rd);

    for (int i = 0; i < RAM_WORDS; i++) begin  // defined contents for the DMA runs
      model_ram[i] = rand_word();
      host_write(ram_addr(i), model_ram[i], 4'hf);
    end
    for (int n = 0; n < 40; n++) begin
      idx = rand_below(RAM_WORDS);
      if (rand_below(2) == 0) begin
        model_ram[idx] = rand_word();
        host_write(ram_addr(idx), model_ram[idx], 4'hf);
      end else begin
        host_read(ram_addr(idx), rd);
        check_word("ram window read", model_ram[idx], rd);
      end
    end

    for (int n = 0; n < 2; n++) begin
      run_dma(1'b1);
      run_dma(1'b0);
    end

    for (int n = 0; n < 4; n++) begin
      delay = rand_below(256);
      addr  = {REGION_DELAY, 8'(delay)};
      host_read(addr, rd);
      check_word("delayed read", 32'(addr), rd);
      // register read timing plus the low address byte
      check_word("delayed read latency", 32'(3 + delay), 32'(read_cycles));
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: dv/tb_clock.sv
// Clock and reset source for the fabric testbench.
// 100 ns clock period, reset held high for the first three rising edges.
`timescale 1ns/100ps

module tb_clock (
  output logic CLK,
  output logic reset
);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    reset = 1'b0;  // released away from the sampling edge
  end

endmodule

// File: verilog/efpga_test_top.sv
// Top of the eFPGA test fabric. Connects the host bus FSM, the read delay
// timer, the register block, the DMA channel and the operand RAM.
// RAM_DEPTH sets the operand RAM size.
`timescale 1ns/100ps

module efpga_test_top
  import efpga_bus_pkg::*;
  import efpga_map_pkg::*;
#(
  parameter int RAM_DEPTH = 256
) (
  input  logic              CLK,
  input  logic              reset,
  input  host_req_t         host_req,
  output host_rsp_t         host_rsp,
  output tcdm_req_t         tcdm_req,
  input  tcdm_rsp_t         tcdm_rsp,
  input  logic [DATA_W-1:0] gpio_in,
  output logic [DATA_W-1:0] gpio_out,
  output logic [DATA_W-1:0] gpio_oe
);

  reg_wr_t           reg_wr;
  logic [11:0]       rd_offset;
  logic [DATA_W-1:0] rd_data;
  ram_acc_t          ram_host;
  ram_acc_t          ram_dma;
  logic [DATA_W-1:0] ram_rdata;  // shared by both owners
  logic              delay_load;
  logic [7:0]        delay_value;
  logic              delay_expired;
  dma_cfg_t          dma_cfg;
  logic              dma_launch;
  logic              dma_busy;

  host_bus_fsm u_host_bus_fsm (
    .CLK(CLK), .reset(reset), .host_req(host_req), .host_rsp(host_rsp),
    .reg_wr(reg_wr), .rd_offset(rd_offset), .rd_data(rd_data),
    .ram_host(ram_host), .ram_host_rdata(ram_rdata), .delay_load(delay_load),
    .delay_value(delay_value), .delay_expired(delay_expired)
  );

  read_delay_timer u_read_delay_timer (
    .CLK(CLK), .reset(reset), .load(delay_load), .value(delay_value),
    .expired(delay_expired)
  );

  ctrl_regs u_ctrl_regs (
    .CLK(CLK), .reset(reset), .reg_wr(reg_wr), .rd_offset(rd_offset),
    .rd_data(rd_data), .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oe(gpio_oe),
    .dma_cfg(dma_cfg), .dma_launch(dma_launch), .dma_busy(dma_busy)
  );

  dma_channel #(.RAM_DEPTH(RAM_DEPTH)) u_dma_channel (
    .CLK(CLK), .reset(reset), .cfg(dma_cfg), .launch(dma_launch), .busy(dma_busy),
    .tcdm_req(tcdm_req), .tcdm_rsp(tcdm_rsp), .ram_acc(ram_dma), .ram_rdata(ram_rdata)
  );

  oper_ram #(.RAM_DEPTH(RAM_DEPTH)) u_oper_ram (
    .CLK(CLK), .host_acc(ram_host), .dma_acc(ram_dma), .dma_owns(dma_busy),
    .rdata(ram_rdata)
  );

endmodule

// File: dma/dma_channel.sv
// Burst DMA between the operand RAM and the TCDM port. A launch latches the
// configuration and moves count words, one TCDM access outstanding at a time.
// Into RAM: TCDM read, then RAM write on valid. Out of RAM: RAM fetch first,
// then a TCDM write of the fetched word.
`timescale 1ns/100ps

module dma_channel
  import efpga_bus_pkg::*;
  import efpga_map_pkg::*;
#(
  parameter int RAM_DEPTH = 256
) (
  input  logic              CLK,
  input  logic              reset,
  input  dma_cfg_t          cfg,
  input  logic              launch,
  output logic              busy,
  output tcdm_req_t         tcdm_req,
  input  tcdm_rsp_t         tcdm_rsp,
  output ram_acc_t          ram_acc,
  input  logic [DATA_W-1:0] ram_rdata
);

  // a burst never runs past the end of the RAM
  localparam logic [7:0] MAX_WORDS = (RAM_DEPTH < 255) ? 8'(RAM_DEPTH) : 8'd255;

  typedef enum logic [1:0] {S_IDLE, S_FETCH, S_REQ, S_WAIT} dma_state_e;

  dma_state_e             state;
  logic                   to_ram_q;
  logic [7:0]             words_q;
  logic [7:0]             idx_q;   // word within the burst
  logic [TCDM_ADDR_W-1:0] addr_q;

  assign busy = state != S_IDLE;

  assign tcdm_req.req   = state == S_REQ;
  assign tcdm_req.wen   = to_ram_q;   // read when filling the ram
  assign tcdm_req.addr  = addr_q;
  assign tcdm_req.wdata = ram_rdata;  // index held since fetch
  assign tcdm_req.be    = '1;

  assign ram_acc.we    = (state == S_WAIT) && to_ram_q && tcdm_rsp.valid;
  assign ram_acc.index = RAM_IDX_W'(idx_q);
  assign ram_acc.wdata = tcdm_rsp.rdata;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state    <= S_IDLE;
      to_ram_q <= 1'b0;
      words_q  <= '0;
      idx_q    <= '0;
      addr_q   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (launch && cfg.count != '0) begin  // zero count does nothing
            to_ram_q <= cfg.to_ram;
            words_q  <= (cfg.count > MAX_WORDS) ? MAX_WORDS : cfg.count;
            idx_q    <= '0;
            addr_q   <= cfg.tcdm_addr;
            state    <= cfg.to_ram ? S_REQ : S_FETCH;
          end
        end
        S_FETCH: state <= S_REQ;  // ram word ready next cycle
        S_REQ: begin
          if (tcdm_rsp.gnt)
            state <= S_WAIT;
        end
        S_WAIT: begin
          if (tcdm_rsp.valid) begin
            idx_q  <= idx_q + 8'd1;
            addr_q <= addr_q + TCDM_ADDR_W'(4);
            if (idx_q + 8'd1 == words_q)
              state <= S_IDLE;
            else
              state <= to_ram_q ? S_REQ : S_FETCH;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: dma/oper_ram.sv
// Single-port operand RAM with registered read. The host port is used
// normally, the DMA port while a burst owns the RAM.
`timescale 1ns/100ps

module oper_ram
  import efpga_bus_pkg::*;
  import efpga_map_pkg::*;
#(
  parameter int RAM_DEPTH = 256
) (
  input  logic              CLK,
  input  ram_acc_t          host_acc,
  input  ram_acc_t          dma_acc,
  input  logic              dma_owns,
  output logic [DATA_W-1:0] rdata
);

  localparam int IDX_W = $clog2(RAM_DEPTH);

  logic [DATA_W-1:0] mem [RAM_DEPTH];
  ram_acc_t          acc;

  assign acc = dma_owns ? dma_acc : host_acc;  // owner select

  always_ff @(posedge CLK) begin
    if (acc.we)
      mem[acc.index[IDX_W-1:0]] <= acc.wdata;
    rdata <= mem[acc.index[IDX_W-1:0]];  // read-before-write
  end

endmodule

// File: verilog/ctrl_regs.sv
// Control and status registers of the fabric: DMA configuration, GPIO out
// and output enable, the DMA launch strobe and the register read mux.
// Writes arrive from the host bus FSM with byte enables.
`timescale 1ns/100ps

module ctrl_regs
  import efpga_bus_pkg::*;
  import efpga_map_pkg::*;
(
  input  logic              CLK,
  input  logic              reset,
  input  reg_wr_t           reg_wr,
  input  logic [11:0]       rd_offset,
  output logic [DATA_W-1:0] rd_data,
  input  logic [DATA_W-1:0] gpio_in,
  output logic [DATA_W-1:0] gpio_out,
  output logic [DATA_W-1:0] gpio_oe,
  output dma_cfg_t          dma_cfg,
  output logic              dma_launch,
  input  logic              dma_busy
);

  // merge the enabled bytes of a write into the old value
  function automatic logic [DATA_W-1:0] merge_be(
    input logic [DATA_W-1:0]   old_val,
    input logic [DATA_W-1:0]   new_val,
    input logic [DATA_W/8-1:0] be
  );
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < DATA_W/8; b++) begin
      if (be[b])
        res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  always_ff @(posedge CLK) begin
    if (reset) begin
      dma_cfg    <= '0;
      gpio_out   <= '0;
      gpio_oe    <= '0;  // pins start as inputs
      dma_launch <= 1'b0;
    end else begin
      dma_launch <= reg_wr.we && (reg_wr.offset == OFS_DMA_LAUNCH);
      if (reg_wr.we) begin
        case (reg_wr.offset)
          OFS_DMA_CFG:  dma_cfg  <= dma_cfg_t'(merge_be(dma_cfg, reg_wr.wdata, reg_wr.be));
          OFS_GPIO_OUT: gpio_out <= merge_be(gpio_out, reg_wr.wdata, reg_wr.be);
          OFS_GPIO_OE:  gpio_oe  <= merge_be(gpio_oe, reg_wr.wdata, reg_wr.be);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (rd_offset)
      OFS_DMA_CFG:    rd_data = dma_cfg;
      OFS_GPIO_OUT:   rd_data = gpio_out;
      OFS_GPIO_OE:    rd_data = gpio_oe;
      OFS_GPIO_IN:    rd_data = gpio_in;
      OFS_DMA_STATUS: rd_data = {{(DATA_W-1){1'b0}}, dma_busy};
      OFS_ID:         rd_data = ID_VALUE;
      default:        rd_data = '0;
    endcase
  end

endmodule

// File: verilog/host_bus_fsm.sv
// Slave side of the host register bus. Detects a new request on the rising
// edge of req, steers writes to the register block or the operand RAM, and
// collects read data from registers, RAM or the delay window.
`timescale 1ns/100ps

module host_bus_fsm
  import efpga_bus_pkg::*;
  import efpga_map_pkg::*;
(
  input  logic              CLK,
  input  logic              reset,
  input  host_req_t         host_req,
  output host_rsp_t         host_rsp,
  output reg_wr_t           reg_wr,
  output logic [11:0]       rd_offset,
  input  logic [DATA_W-1:0] rd_data,
  output ram_acc_t          ram_host,
  input  logic [DATA_W-1:0] ram_host_rdata,
  output logic              delay_load,
  output logic [7:0]        delay_value,
  input  logic              delay_expired
);

  typedef enum logic [1:0] {IDLE, WRITE, READ, READ_WAIT} bus_state_e;

  bus_state_e        state;
  logic              req_q;  // for rising edge of req
  logic              gnt_q;
  logic              valid_q;
  logic [DATA_W-1:0] rdata_q;
  logic              is_ram;
  logic              is_delay;
  logic              is_reg;
  logic              start;

  assign is_ram   = host_req.addr[19:12] == REGION_RAM;
  assign is_delay = host_req.addr[19:8] == REGION_DELAY;
  assign is_reg   = (host_req.addr[19:12] == 8'h00) && !is_delay;
  assign start    = (state == IDLE) && host_req.req && !req_q && !gnt_q;

  // write steering, valid for the single WRITE cycle
  assign reg_wr.we     = (state == WRITE) && is_reg;
  assign reg_wr.offset = host_req.addr[11:0];
  assign reg_wr.wdata  = host_req.wdata;
  assign reg_wr.be     = host_req.be;

  assign ram_host.we    = (state == WRITE) && is_ram;
  assign ram_host.index = host_req.addr[11:2];  // word address
  assign ram_host.wdata = host_req.wdata;

  assign rd_offset   = host_req.addr[11:0];
  assign delay_load  = (state == READ) && is_delay;
  assign delay_value = host_req.addr[7:0];

  assign host_rsp.gnt   = gnt_q;
  assign host_rsp.valid = valid_q;
  assign host_rsp.rdata = rdata_q;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state   <= IDLE;
      req_q   <= 1'b0;
      gnt_q   <= 1'b0;
      valid_q <= 1'b0;
      rdata_q <= '1;
    end else begin
      req_q <= host_req.req;
      case (state)
        IDLE: begin
          valid_q <= gnt_q;  // closes a read
          gnt_q   <= 1'b0;
          if (start) begin
            if (!host_req.wen) begin
              gnt_q <= 1'b1;
              state <= WRITE;
            end else begin
              state <= READ;
            end
          end
        end
        WRITE: begin
          valid_q <= gnt_q;
          gnt_q   <= 1'b0;
          state   <= IDLE;
        end
        READ: begin
          state <= READ_WAIT;
          if (is_delay)
            rdata_q <= {{(DATA_W-ADDR_W){1'b0}}, host_req.addr};
          else if (is_reg)
            rdata_q <= rd_data;
          else
            rdata_q <= '0;  // unmapped, ram overwrites below
        end
        READ_WAIT: begin
          if (is_ram)
            rdata_q <= ram_host_rdata;  // registered ram word
          if (!is_delay || delay_expired) begin
            gnt_q <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: verilog/read_delay_timer.sv
// Down-counter used to stretch a delay-window read by a host-chosen
// number of cycles. Loaded once per read, holds at zero.
`timescale 1ns/100ps

module read_delay_timer (
  input  logic       CLK,
  input  logic       reset,
  input  logic       load,
  input  logic [7:0] value,
  output logic       expired
);

  logic [7:0] count;

  always_ff @(posedge CLK) begin
    if (reset)
      count <= '0;
    else if (load)
      count <= value;
    else if (count != '0)
      count <= count - 8'd1;  // hold at zero
  end

  assign expired = count == '0;

endmodule

// File: common/efpga_map_pkg.sv
// Address map of the test fabric and the internal structs passed between
// the host bus FSM, the register block, the DMA channel and the operand RAM.

package efpga_map_pkg;

  import efpga_bus_pkg::*;

  // register offsets inside page 0
  localparam logic [11:0] OFS_DMA_CFG    = 12'h000;
  localparam logic [11:0] OFS_GPIO_OUT   = 12'h040;
  localparam logic [11:0] OFS_GPIO_OE    = 12'h050;
  localparam logic [11:0] OFS_GPIO_IN    = 12'h060;
  localparam logic [11:0] OFS_DMA_LAUNCH = 12'h200;
  localparam logic [11:0] OFS_DMA_STATUS = 12'h204;
  localparam logic [11:0] OFS_ID         = 12'h800;

  localparam logic [7:0]  REGION_RAM   = 8'h01;   // addr[19:12]
  localparam logic [11:0] REGION_DELAY = 12'h009; // addr[19:8]

  localparam logic [DATA_W-1:0] ID_VALUE = 32'hCA11EF3A;

  localparam int RAM_IDX_W = 10;  // word index into the operand RAM

  typedef struct packed {
    logic                   to_ram;     // set: TCDM read into RAM
    logic [2:0]             rsvd;
    logic [7:0]             count;      // words
    logic [TCDM_ADDR_W-1:0] tcdm_addr;
  } dma_cfg_t;

  typedef struct packed {
    logic                we;
    logic [11:0]         offset;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] be;
  } reg_wr_t;

  typedef struct packed {
    logic                 we;
    logic [RAM_IDX_W-1:0] index;
    logic [DATA_W-1:0]    wdata;
  } ram_acc_t;

endpackage

// File: common/efpga_bus_pkg.sv
// Widths and request/response structs for the host register bus and the
// shared memory (TCDM) port. Imported by every block that touches either bus.

package efpga_bus_pkg;

  localparam int ADDR_W      = 20;  // host address
  localparam int DATA_W      = 32;  // word width on both buses
  localparam int TCDM_ADDR_W = 20;  // byte address on the TCDM port

  typedef struct packed {
    logic                  req;
    logic                  wen;    // low means write
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W/8-1:0]   be;
  } host_req_t;

  typedef struct packed {
    logic              gnt;    // one-cycle pulse
    logic              valid;  // one cycle after gnt
    logic [DATA_W-1:0] rdata;
  } host_rsp_t;

  typedef struct packed {
    logic                   req;
    logic                   wen;  // low means write
    logic [TCDM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]      wdata;
    logic [DATA_W/8-1:0]    be;
  } tcdm_req_t;

  typedef struct packed {
    logic              gnt;
    logic              valid;  // completes reads and writes alike
    logic [DATA_W-1:0] rdata;
  } tcdm_rsp_t;

endpackage
